//--- aexm_bus_pkg.sv
package aexm_bus_pkg;

	localparam int WORD_W    = 32;
	localparam int MEM_DEPTH = 256;

	typedef logic [WORD_W-1:0] word_t;

	// Word address wide enough for the whole memory.
	typedef logic [$clog2(MEM_DEPTH)-1:0] addr_t;

endpackage

//--- aexm_enable.sv
module aexm_enable (
	input  logic CLK,
	input  logic grst,
	input  logic icache_busy,
	input  logic dcache_busy,
	input  logic dSTRLOD,
	input  logic dLOD,
	input  logic dSKIP,
	input  logic fSTALL,
	output logic cpu_mode_memop, // High in normal mode.
	output logic cpu_enable,
	output logic icache_enable,
	output logic dcache_enable
);

	logic out_of_reset;
	logic starter;
	logic just_issued;
	logic x_lod;
	logic x_strlod;
	logic lod_req;
	logic lod_dly;
	logic enter_memop;
	logic exit_memop;
	logic lod_enable;

	assign cpu_enable = (cpu_mode_memop && !icache_busy) || starter;

	assign enter_memop = cpu_mode_memop && (dSTRLOD || fSTALL) && !dSKIP && cpu_enable;

	// A load waits for its own command to finish, anything else for the bus to go quiet.
	assign exit_memop = !cpu_mode_memop && out_of_reset && !icache_busy && !dcache_busy &&
		(x_lod ? lod_dly : !just_issued);

	assign lod_enable = x_lod && !cpu_mode_memop && !lod_req && !dcache_busy && !just_issued;

	assign icache_enable = starter ||
		(cpu_mode_memop ? (cpu_enable && !enter_memop) : exit_memop);

	assign dcache_enable = x_lod ? lod_enable : (exit_memop && x_strlod);

	always_ff @(posedge CLK)
		if (!grst)
		begin
			out_of_reset   <= 1'b0;
			starter        <= 1'b0;
			cpu_mode_memop <= 1'b0;
			just_issued    <= 1'b0;
			x_lod          <= 1'b0;
			x_strlod       <= 1'b0;
			lod_req        <= 1'b0;
			lod_dly        <= 1'b0;
		end
		else
		begin
			out_of_reset <= 1'b1;
			starter      <= !out_of_reset; // One pulse after release.

			// Keeps data commands one at a time.
			just_issued <= dcache_enable;

			if (cpu_enable)
			begin
				x_strlod <= dSTRLOD;
				x_lod    <= dLOD;
			end

			if (cpu_mode_memop)
			begin
				if (enter_memop)
					cpu_mode_memop <= 1'b0;
			end
			else if (exit_memop)
			begin
				cpu_mode_memop <= 1'b1;
				lod_req        <= 1'b0;
				lod_dly        <= 1'b0;
			end
			else
			begin
				if (lod_enable)
					lod_req <= 1'b1;
				lod_dly <= lod_req;
			end
		end

	assert property (@(posedge CLK) disable iff (!grst) dcache_enable |-> !dcache_busy)
		else $error("data command issued while the data port is busy");

endmodule

//--- aexm_isa_pkg.sv
package aexm_isa_pkg;

	localparam int NREGS = 8;
	localparam int RD_W  = $clog2(NREGS);
	localparam int IMM_W = 16;

	typedef enum logic [3:0] {
		OP_LOAD  = 4'h1, // rd <= mem[imm].
		OP_STORE = 4'h2, // mem[imm] <= rd.
		OP_ADDI  = 4'h3, // rd <= rd + sext(imm).
		OP_SKIPZ = 4'h4, // Skip next if rd is zero.
		OP_FENCE = 4'h5,
		OP_HALT  = 4'h6
	} op_t;

	// Layout op[31:28], spare, rd[18:16], imm[15:0].
	typedef struct packed {
		op_t               op;
		logic [11-RD_W:0]  spare;
		logic [RD_W-1:0]   rd;
		logic [IMM_W-1:0]  imm;
	} instr_t;

endpackage

//--- aexm_memsys.sv
module aexm_memsys
	import aexm_isa_pkg::*, aexm_bus_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  logic              CLK,
	input  logic              grst,
	output logic              i_cyc,
	output logic              i_stb,
	output logic [ADDR_W-1:0] i_adr,
	input  word_t             i_dat_r,
	input  logic              i_ack,
	output logic              d_cyc,
	output logic              d_stb,
	output logic              d_we,
	output logic [ADDR_W-1:0] d_adr,
	output word_t             d_dat_w,
	input  word_t             d_dat_r,
	input  logic              d_ack,
	output logic              retire_valid,
	output logic [ADDR_W-1:0] retire_pc,
	output logic [RD_W-1:0]   retire_rd,
	output word_t             retire_data,
	output logic              halted
);

	logic cpu_mode_memop;
	logic cpu_enable;
	logic icache_enable;
	logic dcache_enable;
	logic ifetch_start;
	logic dSTRLOD;
	logic dLOD;
	logic dSKIP;
	logic fSTALL;

	aexm_port_if #(.ADDR_W(ADDR_W), .payload_t(instr_t)) ifetch ();
	aexm_port_if #(.ADDR_W(ADDR_W), .payload_t(word_t))  dmem ();

	assign ifetch_start = icache_enable && !halted; // No fetch after HALT.

	aexm_enable u_enable (
		.CLK            (CLK),
		.grst           (grst),
		.icache_busy    (ifetch.busy),
		.dcache_busy    (dmem.busy),
		.dSTRLOD        (dSTRLOD),
		.dLOD           (dLOD),
		.dSKIP          (dSKIP),
		.fSTALL         (fSTALL),
		.cpu_mode_memop (cpu_mode_memop),
		.cpu_enable     (cpu_enable),
		.icache_enable  (icache_enable),
		.dcache_enable  (dcache_enable)
	);

	aexm_pipe #(.ADDR_W(ADDR_W)) u_pipe (
		.CLK            (CLK),
		.grst           (grst),
		.cpu_enable     (cpu_enable),
		.cpu_mode_memop (cpu_mode_memop),
		.icache_enable  (icache_enable),
		.ifetch         (ifetch),
		.dmem           (dmem),
		.dSTRLOD        (dSTRLOD),
		.dLOD           (dLOD),
		.dSKIP          (dSKIP),
		.fSTALL         (fSTALL),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_data    (retire_data),
		.halted         (halted)
	);

	aexm_wb_port #(.ADDR_W(ADDR_W), .payload_t(instr_t)) u_iport (
		.CLK      (CLK),
		.grst     (grst),
		.start    (ifetch_start),
		.port     (ifetch),
		.cyc      (i_cyc),
		.stb      (i_stb),
		.wb_we    (),
		.wb_adr   (i_adr),
		.wb_dat_w (),
		.wb_dat_r (i_dat_r),
		.ack      (i_ack)
	);

	aexm_wb_port #(.ADDR_W(ADDR_W), .payload_t(word_t)) u_dport (
		.CLK      (CLK),
		.grst     (grst),
		.start    (dcache_enable),
		.port     (dmem),
		.cyc      (d_cyc),
		.stb      (d_stb),
		.wb_we    (d_we),
		.wb_adr   (d_adr),
		.wb_dat_w (d_dat_w),
		.wb_dat_r (d_dat_r),
		.ack      (d_ack)
	);

endmodule

//--- aexm_pipe.sv
module aexm_pipe
	import aexm_isa_pkg::*, aexm_bus_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  logic              CLK,
	input  logic              grst,
	input  logic              cpu_enable,
	input  logic              cpu_mode_memop,
	input  logic              icache_enable,
	aexm_port_if.requester    ifetch,
	aexm_port_if.requester    dmem,
	output logic              dSTRLOD,
	output logic              dLOD,
	output logic              dSKIP,
	output logic              fSTALL,
	output logic              retire_valid,
	output logic [ADDR_W-1:0] retire_pc,
	output logic [RD_W-1:0]   retire_rd,
	output word_t             retire_data,
	output logic              halted
);

	logic [ADDR_W-1:0] pc; // Address of the next fetch.
	logic [ADDR_W-1:0] f_pc;
	logic              f_pend;
	logic              fetch_go;
	instr_t            d_ir;
	logic [ADDR_W-1:0] d_pc;
	logic              d_valid;
	logic              d_halt;
	instr_t            x_ir;
	logic [ADDR_W-1:0] x_pc;
	logic              x_valid;
	logic              x_wen;
	word_t             x_src;
	word_t             x_result;
	word_t             imm_ext;
	word_t             rf [NREGS];

	assign fetch_go = icache_enable && !halted;

	assign ifetch.adr  = pc;
	assign ifetch.wdat = '0;
	assign ifetch.we   = 1'b0;

	assign x_src   = rf[x_ir.rd];
	assign imm_ext = {{(WORD_W-IMM_W){x_ir.imm[IMM_W-1]}}, x_ir.imm};

	assign dmem.adr  = x_ir.imm[ADDR_W-1:0];
	assign dmem.wdat = x_src;
	assign dmem.we   = (x_ir.op == OP_STORE);

	// A true SKIPZ in execute drops whatever sits in decode.
	assign dSKIP   = x_valid && (x_ir.op == OP_SKIPZ) && (x_src == '0);
	assign dLOD    = d_valid && (d_ir.op == OP_LOAD);
	assign dSTRLOD = d_valid && (d_ir.op == OP_LOAD || d_ir.op == OP_STORE);
	assign fSTALL  = d_valid && (d_ir.op == OP_FENCE || d_ir.op == OP_HALT);
	assign d_halt  = d_valid && (d_ir.op == OP_HALT) && !dSKIP;

	always_comb
	begin
		x_wen    = 1'b0;
		x_result = x_src;
		case (x_ir.op)
			OP_ADDI:
			begin
				x_wen    = 1'b1;
				x_result = x_src + imm_ext;
			end
			OP_LOAD:
			begin
				x_wen    = 1'b1;
				x_result = dmem.rdat;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK)
		if (!grst)
		begin
			pc           <= '0;
			f_pend       <= 1'b0;
			d_valid      <= 1'b0;
			x_valid      <= 1'b0;
			halted       <= 1'b0;
			retire_valid <= 1'b0;
			for (int i = 0; i < NREGS; i++)
				rf[i] <= '0;
		end
		else
		begin
			retire_valid <= cpu_enable && x_valid;
			if (fetch_go)
			begin
				pc     <= pc + 1'b1;
				f_pend <= 1'b1;
			end
			else if (cpu_enable)
				f_pend <= 1'b0;
			if (cpu_enable)
			begin
				d_valid <= f_pend && !d_halt && !halted;
				x_valid <= d_valid && !dSKIP && !halted;
				if (d_halt)
					halted <= 1'b1; // HALT still retires on the next step.
				if (x_valid && x_wen)
					rf[x_ir.rd] <= x_result;
			end
		end

	always_ff @(posedge CLK)
	begin
		if (fetch_go)
			f_pc <= pc;
		if (cpu_enable)
		begin
			d_ir        <= ifetch.rdat;
			d_pc        <= f_pc;
			x_ir        <= d_ir;
			x_pc        <= d_pc;
			retire_pc   <= x_pc;
			retire_rd   <= x_ir.rd;
			retire_data <= x_result;
		end
	end

	// Stall mode only lets the start-up step through.
	assert property (@(posedge CLK) disable iff (!grst)
		cpu_enable && !cpu_mode_memop |-> !d_valid && !x_valid)
		else $error("pipeline advanced in stall mode");

endmodule

//--- aexm_port_if.sv
interface aexm_port_if
	import aexm_bus_pkg::*;
#(
	parameter int ADDR_W = 8,
	parameter type payload_t = word_t
) ();

	logic [ADDR_W-1:0] adr;
	word_t             wdat;
	logic              we;
	payload_t          rdat; // Last read data held until the next one.
	logic              busy;

	modport requester (
		output adr,
		output wdat,
		output we,
		input  rdat,
		input  busy
	);

	modport servant (
		input  adr,
		input  wdat,
		input  we,
		output rdat,
		output busy
	);

endinterface

//--- aexm_wb_port.sv
module aexm_wb_port
	import aexm_bus_pkg::*;
#(
	parameter int ADDR_W = 8,
	parameter type payload_t = word_t
) (
	input  logic              CLK,
	input  logic              grst,
	input  logic              start,
	aexm_port_if.servant      port,
	output logic              cyc,
	output logic              stb,
	output logic              wb_we,
	output logic [ADDR_W-1:0] wb_adr,
	output word_t             wb_dat_w,
	input  word_t             wb_dat_r,
	input  logic              ack
);

	logic              active;
	logic [ADDR_W-1:0] adr_q;
	logic              we_q;
	word_t             dat_q;
	payload_t          rdat_q;

	assign cyc      = active;
	assign stb      = active;
	assign wb_we    = active && we_q;
	assign wb_adr   = adr_q;
	assign wb_dat_w = dat_q;

	assign port.busy = active;
	assign port.rdat = rdat_q;

	// Open on start, close after the ack cycle.
	always_ff @(posedge CLK)
		if (!grst)
			active <= 1'b0;
		else if (start)
			active <= 1'b1;
		else if (ack)
			active <= 1'b0;

	always_ff @(posedge CLK)
	begin
		if (start)
		begin
			adr_q <= port.adr;
			we_q  <= port.we;
			dat_q <= port.wdat;
		end
		if (active && ack && !we_q)
			rdat_q <= payload_t'(wb_dat_r);
	end

	assert property (@(posedge CLK) disable iff (!grst) start |-> !port.busy)
		else $error("port started while a transfer is open");

	assert property (@(posedge CLK) disable iff (!grst) stb && !ack |=> stb)
		else $error("stb dropped before ack");

endmodule

//--- sim.f
aexm_isa_pkg.sv
aexm_bus_pkg.sv
aexm_port_if.sv
aexm_enable.sv
aexm_wb_port.sv
aexm_pipe.sv
aexm_memsys.sv
tb_clkgen.sv
tb_checker.sv
tb_aexm.sv

//--- tb_aexm.sv
module tb_aexm
	import aexm_isa_pkg::*, aexm_bus_pkg::*;
();

	localparam int PROG_LEN = 76;
	localparam int TIMEOUT  = PROG_LEN * 2 * 5 * 100 + 100000;

	logic            CLK;
	logic            grst;
	logic            i_cyc;
	logic            i_stb;
	addr_t           i_adr;
	word_t           i_dat_r;
	logic            i_ack;
	logic            d_cyc;
	logic            d_stb;
	logic            d_we;
	addr_t           d_adr;
	word_t           d_dat_w;
	word_t           d_dat_r;
	logic            d_ack;
	logic            retire_valid;
	addr_t           retire_pc;
	logic [RD_W-1:0] retire_rd;
	word_t           retire_data;
	logic            halted;
	logic            done;
	int              errors;
	int              n_retired;
	word_t           imem [MEM_DEPTH];
	word_t           dmem [MEM_DEPTH];
	int              seed;
	int              i_wait;
	int              d_wait;

	tb_clkgen u_clk (.CLK(CLK), .grst(grst));

	aexm_memsys uut (.*);

	tb_checker u_check (.*);

	function automatic word_t encode(input op_t op, input int rd, input int imm);
		instr_t ir;
		ir       = '0;
		ir.op    = op;
		ir.rd    = rd[RD_W-1:0];
		ir.imm   = imm[15:0];
		return word_t'(ir);
	endfunction

	initial
	begin
		int r;
		seed = 32'h00ed_9720;
		i_ack = 1'b0;
		d_ack = 1'b0;
		i_dat_r = '0;
		d_dat_r = '0;
		i_wait = 0;
		d_wait = 0;
		for (int a = 0; a < MEM_DEPTH; a++)
		begin
			imem[a] = encode(OP_HALT, 0, 0);
			dmem[a] = {a[7:0], ~a[7:0], a[7:0] ^ 8'h5a, 8'h3c};
		end
		// Directed ADDI, load/store, both SKIPZ cases and FENCE.
		imem[0]  = encode(OP_ADDI, 1, 5);
		imem[1]  = encode(OP_ADDI, 2, -3);
		imem[2]  = encode(OP_ADDI, 1, 7);
		imem[3]  = encode(OP_STORE, 1, 8'h10);
		imem[4]  = encode(OP_LOAD, 3, 8'h10);
		imem[5]  = encode(OP_SKIPZ, 0, 0);
		imem[6]  = encode(OP_ADDI, 4, 100);
		imem[7]  = encode(OP_SKIPZ, 1, 0);
		imem[8]  = encode(OP_ADDI, 5, 1);
		imem[9]  = encode(OP_FENCE, 0, 0);
		imem[10] = encode(OP_LOAD, 6, 8'h20);
		imem[11] = encode(OP_STORE, 6, 8'h21);
		for (int a = 12; a < PROG_LEN - 2; a++)
		begin
			r = $unsigned($random(seed)) % 5;
			imem[a] = encode(op_t'(r + 1), $random(seed), $random(seed));
			if (r < 2)
				imem[a][15:8] = 8'h00; // Word address only.
		end
		imem[PROG_LEN-2] = encode(OP_ADDI, 7, 1); // Nothing skips the HALT.
		imem[PROG_LEN-1] = encode(OP_HALT, 0, 0);
	end

	// Instruction and data slaves draw from one random stream.
	always @(posedge CLK)
	begin
		#1;
		if (i_ack)
		begin
			i_ack = 1'b0;
			i_wait = $unsigned($random(seed)) % 4;
		end
		else if (i_cyc && i_stb)
		begin
			if (i_wait == 0)
			begin
				i_dat_r = imem[i_adr];
				i_ack = 1'b1;
			end
			else
				i_wait--;
		end
		else
			i_wait = $unsigned($random(seed)) % 4;
		if (d_ack)
		begin
			d_ack = 1'b0;
			d_wait = $unsigned($random(seed)) % 4;
		end
		else if (d_cyc && d_stb)
		begin
			if (d_wait == 0)
			begin
				if (d_we)
					dmem[d_adr] = d_dat_w;
				else
					d_dat_r = dmem[d_adr];
				d_ack = 1'b1;
			end
			else
				d_wait--;
		end
		else
			d_wait = $unsigned($random(seed)) % 4;
	end

	initial
	begin
		wait (done === 1'b1);
		$display("errors %0d, instructions retired %0d", errors, n_retired);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		#TIMEOUT;
		$display("timeout: the program did not reach HALT in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- tb_checker.sv
module tb_checker
	import aexm_isa_pkg::*, aexm_bus_pkg::*;
(
	input  logic            CLK,
	input  logic            grst,
	input  logic            i_cyc,
	input  logic            i_stb,
	input  addr_t           i_adr,
	input  logic            d_cyc,
	input  logic            d_stb,
	input  logic            d_we,
	input  addr_t           d_adr,
	input  word_t           d_dat_w,
	input  logic            d_ack,
	input  logic            retire_valid,
	input  addr_t           retire_pc,
	input  logic [RD_W-1:0] retire_rd,
	input  word_t           retire_data,
	input  logic            halted,
	output logic            done,
	output int              errors,
	output int              n_retired
);

	int    exp_pc[$];
	int    exp_rd[$];
	word_t exp_data[$];
	int    exp_waddr[$];
	word_t exp_wdata[$];
	word_t model_mem [MEM_DEPTH];
	int    n_loads;
	int    n_writes;
	int    n_reads;
	int    n_fetch;
	int    n_dcmd;
	logic  i_cyc_q;
	logic  d_cyc_q;

	// Runs the program one instruction at a time, in program order.
	function automatic void run_model();
		word_t  r [NREGS];
		int     pc;
		instr_t ir;
		logic   skip;
		for (int i = 0; i < MEM_DEPTH; i++)
			model_mem[i] = tb_aexm.dmem[i];
		for (int i = 0; i < NREGS; i++)
			r[i] = '0;
		pc = 0;
		skip = 1'b0;
		n_loads = 0;
		for (int step = 0; step < 1000; step++)
		begin
			ir = instr_t'(tb_aexm.imem[pc % MEM_DEPTH]);
			if (skip)
				skip = 1'b0;
			else
			begin
				case (ir.op)
					OP_LOAD:
					begin
						r[ir.rd] = model_mem[ir.imm[7:0]];
						n_loads++;
					end
					OP_STORE:
					begin
						model_mem[ir.imm[7:0]] = r[ir.rd];
						exp_waddr.push_back(ir.imm[7:0]);
						exp_wdata.push_back(r[ir.rd]);
					end
					OP_ADDI: r[ir.rd] = r[ir.rd] + {{16{ir.imm[15]}}, ir.imm};
					OP_SKIPZ: skip = (r[ir.rd] == '0);
					default: ;
				endcase
				exp_pc.push_back(pc);
				exp_rd.push_back(ir.rd);
				exp_data.push_back(r[ir.rd]);
				if (ir.op == OP_HALT)
					break;
			end
			pc++;
		end
	endfunction

	task automatic check(input string name, input word_t exp, input word_t act);
		if (exp !== act)
		begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic fail(input string what);
		$display("%s", what);
		errors++;
	endtask

	initial
	begin
		done = 1'b0;
		errors = 0;
		n_retired = 0;
		n_writes = 0;
		n_reads = 0;
		n_fetch = 0;
		n_dcmd = 0;
		@(posedge grst);
		run_model();
		wait (halted === 1'b1);
		repeat (20) @(posedge CLK); // Let HALT retire and buses drain.
		if (n_retired != exp_pc.size())
			fail($sformatf("retired %0d instructions, model has %0d",
				n_retired, exp_pc.size()));
		if (n_writes != exp_waddr.size())
			fail($sformatf("saw %0d data writes, model has %0d",
				n_writes, exp_waddr.size()));
		if (n_reads != n_loads)
			fail($sformatf("saw %0d data reads, model has %0d loads", n_reads, n_loads));
		if (n_dcmd != n_reads + n_writes)
			fail("data bus commands overlapped or ended without ack");
		if (i_cyc || d_cyc)
			fail("bus still active after halt");
		for (int i = 0; i < MEM_DEPTH; i++)
			check($sformatf("final_mem[%0d]", i), model_mem[i], tb_aexm.dmem[i]);
		done = 1'b1;
	end

	always @(posedge CLK)
	begin
		i_cyc_q <= i_cyc;
		d_cyc_q <= d_cyc;
		if (grst !== 1'b1)
		begin
			if (i_cyc === 1'b1 || i_stb === 1'b1 || d_cyc === 1'b1 || d_stb === 1'b1 ||
				retire_valid === 1'b1)
				fail("bus cycle or retire seen during reset");
		end
		else
		begin
			if (i_stb !== i_cyc || d_stb !== d_cyc)
				fail("stb and cyc differ on a bus");
			if (n_fetch == 0 && (d_cyc || retire_valid))
				fail("data cycle or retire seen before the first fetch");
			if (i_cyc && !i_cyc_q)
			begin
				if (halted)
					fail("instruction fetch started after halt");
				check($sformatf("fetch_adr[%0d]", n_fetch), n_fetch % MEM_DEPTH, i_adr);
				n_fetch++;
			end
			if (d_cyc && !d_cyc_q)
				n_dcmd++;
			if (d_cyc && d_ack && !d_we)
				n_reads++;
			if (d_cyc && d_ack && d_we)
			begin
				if (n_writes < exp_waddr.size())
				begin
					check($sformatf("store_adr[%0d]", n_writes), exp_waddr[n_writes], d_adr);
					check($sformatf("store_dat[%0d]", n_writes), exp_wdata[n_writes], d_dat_w);
				end
				else
					fail("data write that the program does not make");
				n_writes++;
			end
			if (retire_valid)
			begin
				if (n_retired < exp_pc.size())
				begin
					check($sformatf("retire_pc[%0d]", n_retired), exp_pc[n_retired], retire_pc);
					check($sformatf("retire_rd[%0d]", n_retired), exp_rd[n_retired], retire_rd);
					check($sformatf("retire_data[%0d]", n_retired), exp_data[n_retired],
						retire_data);
				end
				else
					fail("retire beyond the end of the program");
				n_retired++;
			end
		end
	end

endmodule

//--- tb_clkgen.sv
module tb_clkgen (
	output logic CLK,
	output logic grst
);

	initial
	begin
		CLK = 1'b0;
		forever
			#50 CLK = ~CLK;
	end

	initial
	begin
		grst = 1'b0;
		repeat (5) @(posedge CLK);
		#1 grst = 1'b1; // Released just after the edge.
	end

endmodule
